//--- compile.f
addrgen_pkg.sv
lsu_req_fifo.sv
vinsn_ctrl.sv
axi_burst_gen.sv
vec_addrgen.sv
tb_clk_gen.sv
tb_vec_addrgen.sv

//--- tb_vec_addrgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_addrgen;

  localparam longint BeatBytes = 8;
  localparam longint PageBytes = 4096;
  localparam longint MaxBeats  = 256;
  // Every test finishes within a few hundred cycles
  localparam int MaxCycles = 5000;

  logic                    clk_i;
  logic                    rst_ni;
  addrgen_pkg::vinsn_req_t vinsn;
  logic                    vinsn_valid;
  logic                    ack;
  logic                    error;
  addrgen_pkg::ax_req_t    ar;
  logic                    ar_valid;
  logic                    ar_ready;
  addrgen_pkg::ax_req_t    aw;
  logic                    aw_valid;
  logic                    aw_ready;
  addrgen_pkg::lsu_req_t   lsu_req;
  logic                    lsu_valid;
  logic                    lsu_ready;

  addrgen_pkg::ax_req_t  ar_seen[$];
  addrgen_pkg::ax_req_t  aw_seen[$];
  addrgen_pkg::lsu_req_t lsu_seen[$];
  addrgen_pkg::ax_req_t  exp_ax[$];
  logic                  exp_is_load;
  logic                  ack_error;
  addrgen_pkg::ax_req_t  ar_prev;
  logic                  ar_stalled = 1'b0;
  int                    errors     = 0;
  int                    tests_ok   = 0;
  int                    tests_bad  = 0;
  int                    cycles     = 0;
  logic [31:0]           lcg_state  = 32'd87;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  vec_addrgen i_vec_addrgen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn),
    .vinsn_valid_i   (vinsn_valid),
    .ack_o           (ack),
    .error_o         (error),
    .axi_ar_o        (ar),
    .axi_ar_valid_o  (ar_valid),
    .axi_ar_ready_i  (ar_ready),
    .axi_aw_o        (aw),
    .axi_aw_valid_o  (aw_valid),
    .axi_aw_ready_i  (aw_ready),
    .lsu_req_o       (lsu_req),
    .lsu_req_valid_o (lsu_valid),
    .lsu_req_ready_i (lsu_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic addrgen_pkg::lsu_req_t to_lsu(addrgen_pkg::ax_req_t ax, logic is_load);
    return '{addr: ax.addr, len: ax.len, size: ax.size, is_load: is_load};
  endfunction

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic clear_lists();
    ar_seen.delete();
    aw_seen.delete();
    lsu_seen.delete();
  endtask

  // Reference model of the burst and stride rules
  task automatic build_expected(input addrgen_pkg::vec_op_e op, input longint base,
                                input longint vl, input longint stride,
                                input addrgen_pkg::vew_e vew);
    longint a;
    longint l;
    longint a0;
    longint e;
    longint n;
    longint last;
    longint page_end;
    longint data_end;
    addrgen_pkg::ax_req_t item;
    exp_ax.delete();
    exp_is_load = (op == addrgen_pkg::OP_VLE) || (op == addrgen_pkg::OP_VLSE);
    e = longint'(1) << vew;
    a = base;
    l = vl;
    item.burst = addrgen_pkg::BurstIncr;
    item.cache = addrgen_pkg::CacheModifiable;
    if ((op == addrgen_pkg::OP_VLSE) || (op == addrgen_pkg::OP_VSSE)) begin
      for (longint i = 0; i < vl; i++) begin
        item.addr = addrgen_pkg::addr_t'(base + i * stride);
        item.len  = '0;
        item.size = addrgen_pkg::ax_size_t'(vew);
        exp_ax.push_back(item);
      end
    end else begin
      while (l > 0) begin
        a0       = a - (a % BeatBytes);
        last     = a0 + MaxBeats * BeatBytes - 1;
        page_end = a0 - (a0 % PageBytes) + PageBytes - 1;
        data_end = a + l * e - 1;
        data_end = data_end - (data_end % BeatBytes) + BeatBytes - 1;
        if (page_end < last) last = page_end;
        if (data_end < last) last = data_end;
        item.addr = addrgen_pkg::addr_t'(a);
        item.len  = addrgen_pkg::beat_len_t'((last - a0) / BeatBytes);
        item.size = addrgen_pkg::ax_size_t'($clog2(BeatBytes));
        exp_ax.push_back(item);
        n = (last - a + 1) / e;
        l = (n >= l) ? 0 : l - n;
        a = last + 1;
      end
    end
  endtask

  task automatic start_insn(input addrgen_pkg::vec_op_e op, input longint base,
                            input longint vl, input longint stride,
                            input addrgen_pkg::vew_e vew);
    @(posedge clk_i);
    #2;
    vinsn.op        = op;
    vinsn.base_addr = addrgen_pkg::addr_t'(base);
    vinsn.vl        = addrgen_pkg::vlen_t'(vl);
    vinsn.stride    = addrgen_pkg::stride_t'(stride);
    vinsn.vew       = vew;
    vinsn_valid     = 1'b1;
  endtask

  // Called on the falling edge where the acknowledge is seen
  task automatic release_insn();
    ack_error = error;
    @(posedge clk_i);
    #2;
    vinsn_valid = 1'b0;
    ar_ready    = 1'b1;
  endtask

  task automatic wait_ack();
    do @(negedge clk_i); while (!ack);
    release_insn();
  endtask

  task automatic drain_queue();
    do @(negedge clk_i); while (lsu_valid);
  endtask

  task automatic run_insn(input addrgen_pkg::vec_op_e op, input longint base,
                          input longint vl, input longint stride,
                          input addrgen_pkg::vew_e vew);
    clear_lists();
    build_expected(op, base, vl, stride, vew);
    start_insn(op, base, vl, stride, vew);
    wait_ack();
    drain_queue();
  endtask

  task automatic compare_traffic();
    addrgen_pkg::ax_req_t got[$];
    string                name;
    if (exp_is_load) begin
      got  = ar_seen;
      name = "axi_ar_o";
      check("axi_aw transfers", 0, aw_seen.size());
    end else begin
      got  = aw_seen;
      name = "axi_aw_o";
      check("axi_ar transfers", 0, ar_seen.size());
    end
    check({name, " transfers"}, exp_ax.size(), got.size());
    check("lsu_req_o pops", exp_ax.size(), lsu_seen.size());
    for (int i = 0; i < exp_ax.size(); i++) begin
      if (i < got.size()) check(name, exp_ax[i], got[i]);
      if (i < lsu_seen.size()) check("lsu_req_o", to_lsu(exp_ax[i], exp_is_load), lsu_seen[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////////////////////////////////////////

  // Sampled mid-cycle, where every input and output is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ar_stalled) begin
        check("axi_ar_valid_o held", 1, ar_valid);
        check("axi_ar_o held", ar_prev, ar);
      end
      ar_stalled = ar_valid && !ar_ready;
      ar_prev    = ar;
      if (ar_valid && ar_ready) ar_seen.push_back(ar);
      if (aw_valid && aw_ready) aw_seen.push_back(aw);
      if (lsu_valid && lsu_ready) lsu_seen.push_back(lsu_req);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int errors_before;
    errors_before = errors;
    @(negedge clk_i);
    check("ack_o", 0, ack);
    check("error_o", 0, error);
    check("axi_ar_valid_o", 0, ar_valid);
    check("axi_aw_valid_o", 0, aw_valid);
    check("lsu_req_valid_o", 0, lsu_valid);
    finish_test("reset values", errors_before);
  endtask

  task automatic test_regular(input string name, input addrgen_pkg::vec_op_e op,
                              input longint base, input longint vl,
                              input longint stride, input addrgen_pkg::vew_e vew);
    int errors_before;
    errors_before = errors;
    run_insn(op, base, vl, stride, vew);
    compare_traffic();
    check("error_o", 0, ack_error);
    finish_test(name, errors_before);
  endtask

  task automatic test_misaligned();
    int errors_before;
    errors_before = errors;
    run_insn(addrgen_pkg::OP_VLE, 32'h1002, 4, 0, addrgen_pkg::EW32);
    repeat (5) @(negedge clk_i);
    check("error_o", 1, ack_error);
    check("axi_ar transfers", 0, ar_seen.size());
    check("axi_aw transfers", 0, aw_seen.size());
    check("lsu_req_o pops", 0, lsu_seen.size());
    finish_test("misaligned load", errors_before);
  endtask

  task automatic test_ar_stall();
    int          errors_before;
    int          stall_left;
    logic [31:0] rnd;
    errors_before = errors;
    stall_left    = 0;
    clear_lists();
    build_expected(addrgen_pkg::OP_VLE, 32'h20000, 600, 0, addrgen_pkg::EW64);
    start_insn(addrgen_pkg::OP_VLE, 32'h20000, 600, 0, addrgen_pkg::EW64);
    do begin
      @(posedge clk_i);
      #2;
      if (stall_left == 0) begin
        rnd        = lcg_next();
        ar_ready   = ~ar_ready;
        stall_left = int'(rnd[17:16]) + 1;
      end
      stall_left--;
      @(negedge clk_i);
    end while (!ack);
    release_insn();
    drain_queue();
    compare_traffic();
    check("error_o", 0, ack_error);
    finish_test("load under AR stalls", errors_before);
  endtask

  task automatic test_order();
    int                   errors_before;
    addrgen_pkg::ax_req_t load_ax;
    errors_before = errors;
    clear_lists();
    @(posedge clk_i);
    #2;
    lsu_ready = 1'b0;
    build_expected(addrgen_pkg::OP_VLE, 32'h3000, 16, 0, addrgen_pkg::EW32);
    load_ax = exp_ax[0];
    start_insn(addrgen_pkg::OP_VLE, 32'h3000, 16, 0, addrgen_pkg::EW32);
    wait_ack();
    check("axi_ar transfers", 1, ar_seen.size());
    // The store must wait behind the queued load entry
    build_expected(addrgen_pkg::OP_VSE, 32'h5000, 8, 0, addrgen_pkg::EW64);
    start_insn(addrgen_pkg::OP_VSE, 32'h5000, 8, 0, addrgen_pkg::EW64);
    repeat (20) @(negedge clk_i);
    check("axi_aw transfers before pop", 0, aw_seen.size());
    @(posedge clk_i);
    #2;
    lsu_ready = 1'b1;
    wait_ack();
    drain_queue();
    check("lsu_req_o pops", 2, lsu_seen.size());
    if (lsu_seen.size() == 2) begin
      check("lsu_req_o", to_lsu(load_ax, 1'b1), lsu_seen[0]);
      void'(lsu_seen.pop_front());
    end
    ar_seen.delete();
    compare_traffic();
    check("error_o", 0, ack_error);
    finish_test("store after queued load", errors_before);
  endtask

  initial begin
    vinsn       = '0;
    vinsn_valid = 1'b0;
    ar_ready    = 1'b1;
    aw_ready    = 1'b1;
    lsu_ready   = 1'b1;
    ack_error   = 1'b0;
    wait (rst_ni);
    test_reset();
    test_regular("unit-stride load", addrgen_pkg::OP_VLE, 32'h1000, 16, 0,
                 addrgen_pkg::EW32);
    test_regular("store across page", addrgen_pkg::OP_VSE, 32'h1F80, 64, 0,
                 addrgen_pkg::EW64);
    test_regular("long load", addrgen_pkg::OP_VLE, 32'h10000, 600, 0,
                 addrgen_pkg::EW64);
    test_regular("strided store", addrgen_pkg::OP_VSSE, 32'h400, 5, 12,
                 addrgen_pkg::EW16);
    test_misaligned();
    test_ar_stall();
    test_order();
    $display("Tests ok %0d, tests with errors %0d", tests_ok, tests_bad);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset is released just after an edge, like any other input
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- vec_addrgen.sv
`timescale 1ns/1ps
`default_nettype none

module vec_addrgen #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned QueueDepth   = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire addrgen_pkg::vinsn_req_t vinsn_i,
  input  wire logic                    vinsn_valid_i,
  output logic                         ack_o,
  output logic                         error_o,
  output addrgen_pkg::ax_req_t         axi_ar_o,
  output logic                         axi_ar_valid_o,
  input  wire logic                    axi_ar_ready_i,
  output addrgen_pkg::ax_req_t         axi_aw_o,
  output logic                         axi_aw_valid_o,
  input  wire logic                    axi_aw_ready_i,
  output addrgen_pkg::lsu_req_t        lsu_req_o,
  output logic                         lsu_req_valid_o,
  input  wire logic                    lsu_req_ready_i
);

  addrgen_pkg::mem_req_t mem_req;
  logic                  mem_req_valid;
  logic                  mem_req_done;

  addrgen_pkg::lsu_req_t queue_req;
  logic                  queue_push;
  logic                  queue_full;
  logic                  queue_empty;

  assign lsu_req_valid_o = ~queue_empty;

  vinsn_ctrl i_vinsn_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .ack_o           (ack_o),
    .error_o         (error_o),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_done_i  (mem_req_done)
  );

  axi_burst_gen #(
    .AxiDataWidth (AxiDataWidth)
  ) i_axi_burst_gen (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .mem_req_i            (mem_req),
    .mem_req_valid_i      (mem_req_valid),
    .mem_req_done_o       (mem_req_done),
    .axi_ar_o             (axi_ar_o),
    .axi_ar_valid_o       (axi_ar_valid_o),
    .axi_ar_ready_i       (axi_ar_ready_i),
    .axi_aw_o             (axi_aw_o),
    .axi_aw_valid_o       (axi_aw_valid_o),
    .axi_aw_ready_i       (axi_aw_ready_i),
    .queue_push_o         (queue_push),
    .queue_req_o          (queue_req),
    .queue_full_i         (queue_full),
    .queue_empty_i        (queue_empty),
    .queue_head_is_load_i (lsu_req_o.is_load)
  );

  // Pop only on a completed valid/ready handshake
  lsu_req_fifo #(
    .QueueDepth (QueueDepth)
  ) i_lsu_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (queue_push),
    .data_i  (queue_req),
    .full_o  (queue_full),
    .pop_i   (lsu_req_ready_i & lsu_req_valid_o),
    .data_o  (lsu_req_o),
    .empty_o (queue_empty)
  );

endmodule

`default_nettype wire

//--- axi_burst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_gen #(
  parameter int unsigned AxiDataWidth = 64
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire addrgen_pkg::mem_req_t mem_req_i,
  input  wire logic                  mem_req_valid_i,
  output logic                       mem_req_done_o,
  output addrgen_pkg::ax_req_t       axi_ar_o,
  output logic                       axi_ar_valid_o,
  input  wire logic                  axi_ar_ready_i,
  output addrgen_pkg::ax_req_t       axi_aw_o,
  output logic                       axi_aw_valid_o,
  input  wire logic                  axi_aw_ready_i,
  output logic                       queue_push_o,
  output addrgen_pkg::lsu_req_t      queue_req_o,
  input  wire logic                  queue_full_i,
  input  wire logic                  queue_empty_i,
  input  wire logic                  queue_head_is_load_i
);

  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned BeatLog   = $clog2(BeatBytes);

  localparam addrgen_pkg::addr_t BeatMask   = addrgen_pkg::addr_t'(BeatBytes - 1);
  localparam addrgen_pkg::addr_t PageMask   =
    addrgen_pkg::addr_t'((1 << addrgen_pkg::PageBits) - 1);
  localparam addrgen_pkg::addr_t BurstBytes =
    addrgen_pkg::addr_t'(addrgen_pkg::MaxBurstBeats * BeatBytes);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    REQUESTING
  } state_e;

  // Last byte of the next burst, limited by burst size, page and data end
  function automatic addrgen_pkg::addr_t burst_last(addrgen_pkg::addr_t addr,
                                                    addrgen_pkg::vlen_t len,
                                                    addrgen_pkg::vew_e  vew);
    addrgen_pkg::addr_t base;
    addrgen_pkg::addr_t last;
    addrgen_pkg::addr_t page_end;
    addrgen_pkg::addr_t data_end;
    base     = addr & ~BeatMask;
    last     = base + BurstBytes - 1'b1;
    page_end = base | PageMask;
    data_end = (addr + (addrgen_pkg::addr_t'(len) << vew) - 1'b1) | BeatMask;
    if (page_end < last) begin
      last = page_end;
    end
    if (data_end < last) begin
      last = data_end;
    end
    return last;
  endfunction

  state_e                state_q;
  state_e                state_d;
  addrgen_pkg::mem_req_t req_q;
  addrgen_pkg::mem_req_t req_d;
  addrgen_pkg::addr_t    start_q;
  addrgen_pkg::addr_t    start_d;
  addrgen_pkg::addr_t    end_q;
  addrgen_pkg::addr_t    end_d;
  addrgen_pkg::addr_t    next_q;
  addrgen_pkg::addr_t    next_d;

  addrgen_pkg::beat_len_t beat_len;
  addrgen_pkg::ax_size_t  beat_size;
  addrgen_pkg::addr_t     consumed;
  addrgen_pkg::addr_t     next_addr;
  addrgen_pkg::vlen_t     next_len;
  addrgen_pkg::ax_req_t   ax_req;
  logic                   can_issue;
  logic                   ax_ready;
  logic                   fire;

  ////////////////////////////////////////////////////////////////////////////
  // Current transaction
  ////////////////////////////////////////////////////////////////////////////

  assign beat_len  = req_q.is_burst ?
                     addrgen_pkg::beat_len_t'((end_q - start_q) >> BeatLog) : '0;
  assign beat_size = req_q.is_burst ?
                     addrgen_pkg::ax_size_t'(BeatLog) : addrgen_pkg::ax_size_t'(req_q.vew);

  // Elements covered by this burst
  assign consumed = (end_q - req_q.addr + 1'b1) >> req_q.vew;

  always_comb begin
    if (req_q.is_burst) begin
      next_addr = next_q;
      if (addrgen_pkg::addr_t'(req_q.len) <= consumed) begin
        next_len = '0;
      end else begin
        next_len = req_q.len - addrgen_pkg::vlen_t'(consumed);
      end
    end else begin
      next_addr = req_q.addr + addrgen_pkg::addr_t'(req_q.stride);
      next_len  = req_q.len - 1'b1;
    end
  end

  // Keep response order by never mixing directions in the queue
  assign can_issue = (state_q == REQUESTING) && !queue_full_i &&
                     (queue_empty_i || (queue_head_is_load_i == req_q.is_load));
  assign ax_ready  = req_q.is_load ? axi_ar_ready_i : axi_aw_ready_i;
  assign fire      = can_issue && ax_ready;

  assign ax_req = '{
    addr:  req_q.addr,
    len:   beat_len,
    size:  beat_size,
    burst: addrgen_pkg::BurstIncr,
    cache: addrgen_pkg::CacheModifiable
  };

  assign axi_ar_o       = ax_req;
  assign axi_aw_o       = ax_req;
  assign axi_ar_valid_o = can_issue && req_q.is_load;
  assign axi_aw_valid_o = can_issue && !req_q.is_load;

  assign queue_push_o = fire;
  assign queue_req_o  = '{
    addr:    req_q.addr,
    len:     beat_len,
    size:    beat_size,
    is_load: req_q.is_load
  };

  // An empty request finishes right after setup
  assign mem_req_done_o = (fire && (next_len == '0)) ||
                          ((state_q == SETUP) && (req_q.len == '0));

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    req_d   = req_q;
    start_d = start_q;
    end_d   = end_q;
    next_d  = next_q;
    case (state_q)
      IDLE: begin
        if (mem_req_valid_i) begin
          req_d   = mem_req_i;
          state_d = SETUP;
        end
      end
      SETUP: begin
        start_d = req_q.addr & ~BeatMask;
        end_d   = burst_last(req_q.addr, req_q.len, req_q.vew);
        next_d  = end_d + 1'b1;
        state_d = (req_q.len == '0) ? IDLE : REQUESTING;
      end
      REQUESTING: begin
        if (fire) begin
          req_d.addr = next_addr;
          req_d.len  = next_len;
          start_d    = next_addr & ~BeatMask;
          end_d      = burst_last(next_addr, next_len, req_q.vew);
          next_d     = end_d + 1'b1;
          if (next_len == '0) begin
            state_d = IDLE;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q   <= req_d;
    start_q <= start_d;
    end_q   <= end_d;
    next_q  <= next_d;
  end

  // A stalled request holds even when the queue drains meanwhile
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_aw_valid_o && !axi_aw_ready_i |=> axi_aw_valid_o && $stable(axi_aw_o));

endmodule

`default_nettype wire

//--- vinsn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vinsn_ctrl (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire addrgen_pkg::vinsn_req_t vinsn_i,
  input  wire logic                    vinsn_valid_i,
  output logic                         ack_o,
  output logic                         error_o,
  output addrgen_pkg::mem_req_t        mem_req_o,
  output logic                         mem_req_valid_o,
  input  wire logic                    mem_req_done_i
);

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  addrgen_pkg::vinsn_req_t vinsn_q;
  addrgen_pkg::addr_t      align_mask;
  logic                    misaligned;
  // Burst generator has finished, acknowledge on the next cycle
  logic                    done_q;

  // Low address bits must be zero for the element width
  assign align_mask = (addrgen_pkg::addr_t'(1) << vinsn_q.vew) - 1'b1;
  assign misaligned = |(vinsn_q.base_addr & align_mask);

  assign mem_req_o = '{
    addr:     vinsn_q.base_addr,
    len:      vinsn_q.vl,
    stride:   vinsn_q.stride,
    vew:      vinsn_q.vew,
    is_load:  vinsn_q.op inside {addrgen_pkg::OP_VLE, addrgen_pkg::OP_VLSE},
    is_burst: vinsn_q.op inside {addrgen_pkg::OP_VLE, addrgen_pkg::OP_VSE}
  };

  assign mem_req_valid_o = ((state_q == CHECK) && !misaligned) ||
                           ((state_q == ISSUE) && !done_q);
  assign error_o         = (state_q == CHECK) && misaligned;
  assign ack_o           = error_o || ((state_q == ISSUE) && done_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (vinsn_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        state_d = misaligned ? IDLE : ISSUE;
      end
      ISSUE: begin
        if (done_q) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != ISSUE) begin
        done_q <= 1'b0;
      end else if (mem_req_done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && vinsn_valid_i) begin
      vinsn_q <= vinsn_i;
    end
  end

  // The burst generator reports done once and only for an issued request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_done_i |-> (state_q == ISSUE) && !done_q);

endmodule

`default_nettype wire

//--- lsu_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_fifo #(
  parameter int unsigned QueueDepth = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  push_i,
  input  wire addrgen_pkg::lsu_req_t data_i,
  output logic                       full_o,
  input  wire logic                  pop_i,
  output addrgen_pkg::lsu_req_t      data_o,
  output logic                       empty_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   count_t;

  addrgen_pkg::lsu_req_t mem_q [QueueDepth];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;

  assign full_o  = (count_q == count_t'(QueueDepth));
  assign empty_o = (count_q == '0);
  // Head is read straight from storage
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Depth is a power of two, so the pointers wrap on their own
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Both sides of the queue sit in other modules
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- addrgen_pkg.sv
`default_nettype none

package addrgen_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned PageBits      = 12;
  localparam int unsigned MaxBurstBeats = 256;

  localparam logic [1:0] BurstIncr       = 2'b01;
  localparam logic [3:0] CacheModifiable = 4'b0010;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [15:0]          vlen_t;
  typedef logic signed [31:0]   stride_t;
  // Number of beats minus one
  typedef logic [7:0]           beat_len_t;
  typedef logic [2:0]           ax_size_t;

  // Encoded as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    OP_VLE,
    OP_VSE,
    OP_VLSE,
    OP_VSSE
  } vec_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Interface structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vec_op_e op;
    addr_t   base_addr;
    vlen_t   vl;
    stride_t stride;
    vew_e    vew;
  } vinsn_req_t;

  typedef struct packed {
    addr_t   addr;
    vlen_t   len;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    logic    is_burst;
  } mem_req_t;

  typedef struct packed {
    addr_t      addr;
    beat_len_t  len;
    ax_size_t   size;
    logic [1:0] burst;
    logic [3:0] cache;
  } ax_req_t;

  typedef struct packed {
    addr_t     addr;
    beat_len_t len;
    ax_size_t  size;
    logic      is_load;
  } lsu_req_t;

endpackage

`default_nettype wire
